// File: rtl/ipu_settings.svh
////////////////////////////////////////////////////////////////////////////
// Build-time sizes of the SIMD integer unit and its result queue.
// Include it wherever word width or queue depth is needed.
////////////////////////////////////////////////////////////////////////////

`ifndef IPU_SETTINGS_SVH
`define IPU_SETTINGS_SVH

// Datapath word width in bits
`define IPU_ELEN 32

// Result queue entries, a power of two
`define IPU_QUEUE_DEPTH 4

// Number of 8-bit elements in one word
`define IPU_NUM_ELEM8 4

`endif

// File: rtl/ipu_op_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Operation codes and element widths understood by the SIMD integer unit.
////////////////////////////////////////////////////////////////////////////

package ipu_op_pkg;

  // Integer operations, two codes left free
  typedef enum logic [3:0] {
    VADD    = 4'd0,
    VSUB    = 4'd1,
    VADC    = 4'd2,
    VAND    = 4'd3,
    VOR     = 4'd4,
    VXOR    = 4'd5,
    VMINU   = 4'd6,
    VMIN    = 4'd7,
    VMAXU   = 4'd8,
    VMAX    = 4'd9,
    VMUL    = 4'd10,
    VMULH   = 4'd11,
    VMULHU  = 4'd12,
    VMULHSU = 4'd13
  } op_e;

  // Element width of a word
  // 2'b11 is not a valid width and decodes like EW_32
  typedef enum logic [1:0] {
    EW_8  = 2'b00,
    EW_16 = 2'b01,
    EW_32 = 2'b10
  } sew_e;

endpackage

// File: rtl/ipu_data_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Data types shared by the distributor, the collector and the model.
////////////////////////////////////////////////////////////////////////////

`include "ipu_settings.svh"

package ipu_data_pkg;

  // One operand or result word, seen at each element width
  typedef union packed {
    logic [`IPU_NUM_ELEM8-1:0][7:0]    e8;
    logic [`IPU_NUM_ELEM8/2-1:0][15:0] e16;
    logic [`IPU_ELEN-1:0]              e32;
  } elem_word_u;

  // Carry-in per element slot, bit i for element i
  // Bits above the element count of the width are ignored
  typedef logic [`IPU_NUM_ELEM8-1:0] carry_t;

endpackage

// File: rtl/simd_lane.sv
////////////////////////////////////////////////////////////////////////////
// One integer lane of the SIMD unit. Computes one element per operation and
// keeps it in an output register until the downstream side takes it.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module simd_lane #(
  parameter int unsigned Width = 32
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  ipu_op_pkg::op_e     operation_i,
  input  logic                operation_valid_i,
  input  logic [Width-1:0]    op_s1_i,
  input  logic [Width-1:0]    op_s2_i,
  input  logic [Width-1:0]    op_d_i,
  input  logic                is_signed_i,
  input  logic                carry_i,
  input  ipu_op_pkg::sew_e    sew_i,
  input  logic                result_ready_i,
  output logic [Width-1:0]    result_o,
  output logic                result_valid_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////////////////////

  logic                      s1_sign;
  logic                      s2_sign;
  logic signed [Width:0]     s1_ext;
  logic signed [Width:0]     s2_ext;
  logic signed [2*Width+1:0] product;
  logic                      s1_less;
  logic [5:0]                high_shift;
  logic [Width-1:0]          result_d;

  // Source 1 stays unsigned for the signed-by-unsigned multiply
  assign s1_sign = is_signed_i && (operation_i != ipu_op_pkg::VMULHSU) && op_s1_i[Width-1];
  assign s2_sign = is_signed_i && op_s2_i[Width-1];

  // One extra bit lets signed and unsigned share a comparator and multiplier
  assign s1_ext = {s1_sign, op_s1_i};
  assign s2_ext = {s2_sign, op_s2_i};

  assign product = s1_ext * s2_ext;
  assign s1_less = s1_ext < s2_ext;

  // High half sits above the element, which may be narrower than the lane
  always_comb begin
    unique case (sew_i)
      ipu_op_pkg::EW_8:  high_shift = 6'd8;
      ipu_op_pkg::EW_16: high_shift = 6'd16;
      default:           high_shift = 6'd32;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : alu
    unique case (operation_i)
      ipu_op_pkg::VADD: result_d = op_s1_i + op_s2_i;
      // Subtract source 1 from source 2
      ipu_op_pkg::VSUB: result_d = op_s2_i - op_s1_i;
      ipu_op_pkg::VADC: result_d = op_s1_i + op_s2_i + Width'(carry_i);
      ipu_op_pkg::VAND: result_d = op_s1_i & op_s2_i;
      ipu_op_pkg::VOR:  result_d = op_s1_i | op_s2_i;
      ipu_op_pkg::VXOR: result_d = op_s1_i ^ op_s2_i;

      // Signedness comes in through is_signed_i
      ipu_op_pkg::VMIN,
      ipu_op_pkg::VMINU: result_d = s1_less ? op_s1_i : op_s2_i;
      ipu_op_pkg::VMAX,
      ipu_op_pkg::VMAXU: result_d = s1_less ? op_s2_i : op_s1_i;

      ipu_op_pkg::VMUL: result_d = product[Width-1:0];
      ipu_op_pkg::VMULH,
      ipu_op_pkg::VMULHU,
      ipu_op_pkg::VMULHSU: result_d = Width'(product >> high_shift);

      // Free opcodes leave the destination element as it was
      default: result_d = op_d_i;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  logic             valid_q;
  logic [Width-1:0] result_q;
  logic             load;

  // Take a new element when empty or when the held one leaves
  assign load = !valid_q || result_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= operation_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load && operation_valid_i) begin
      result_q <= result_d;
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = valid_q;

endmodule

// File: rtl/simd_ipu.sv
////////////////////////////////////////////////////////////////////////////
// Splits a word into elements over four lanes of 8, 8, 16 and 32 bits and
// joins their results back into one word. Narrow elements in wide lanes are
// sign or zero extended according to the operation.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "ipu_settings.svh"

module simd_ipu (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  ipu_op_pkg::op_e          operation_i,
  input  logic                     operation_valid_i,
  input  ipu_op_pkg::sew_e         sew_i,
  input  ipu_data_pkg::elem_word_u op_s1_i,
  input  ipu_data_pkg::elem_word_u op_s2_i,
  input  ipu_data_pkg::elem_word_u op_d_i,
  input  ipu_data_pkg::carry_t     carry_i,
  input  logic                     result_ready_i,
  output logic                     op_ready_o,
  output ipu_data_pkg::elem_word_u result_o,
  output logic                     result_valid_o
);

  // Element idx of the word, extended to the full word width
  function automatic logic [`IPU_ELEN-1:0] elem_ext(ipu_data_pkg::elem_word_u word,
                                                   ipu_op_pkg::sew_e sew,
                                                   logic [1:0] idx,
                                                   logic sgn);
    logic [`IPU_ELEN-1:0] val;
    unique case (sew)
      ipu_op_pkg::EW_8:  val = {{24{sgn & word.e8[idx][7]}}, word.e8[idx]};
      ipu_op_pkg::EW_16: val = {{16{sgn & word.e16[idx[0]][15]}}, word.e16[idx[0]]};
      default:           val = word.e32;
    endcase
    return val;
  endfunction

  logic                     is_signed;
  logic [2:0]               src_sgn;
  ipu_data_pkg::elem_word_u src [3];
  logic [1:0]               idx16;
  logic [1:0]               idx32;
  logic                     lane_go;

  // Per lane operands, index 0 is s1, 1 is s2, 2 is d
  logic [2:0][7:0]          ops8_0;
  logic [2:0][7:0]          ops8_1;
  logic [2:0][15:0]         ops16;
  logic [2:0][31:0]         ops32;

  logic [7:0]               res8_0;
  logic [7:0]               res8_1;
  logic [15:0]              res16;
  logic [31:0]              res32;
  logic                     valid32;
  ipu_op_pkg::sew_e         sew_q;

  assign is_signed = operation_i inside {ipu_op_pkg::VMIN, ipu_op_pkg::VMAX,
                                         ipu_op_pkg::VMULH, ipu_op_pkg::VMULHSU};

  assign src[0] = op_s1_i;
  assign src[1] = op_s2_i;
  assign src[2] = op_d_i;

  // Source 1 of the signed-by-unsigned multiply is zero extended
  assign src_sgn = {is_signed, is_signed, is_signed && (operation_i != ipu_op_pkg::VMULHSU)};

  ////////////////////////////////////////////////////////////////////////////
  // Distributor
  ////////////////////////////////////////////////////////////////////////////

  // Which element the 16 and 32 bit lanes take
  always_comb begin
    unique case (sew_i)
      ipu_op_pkg::EW_8: begin
        idx16 = 2'd2;
        idx32 = 2'd3;
      end
      ipu_op_pkg::EW_16: begin
        idx16 = 2'd0;
        idx32 = 2'd1;
      end
      default: begin
        idx16 = 2'd0;
        idx32 = 2'd0;
      end
    endcase
  end

  always_comb begin : distributor
    for (int k = 0; k < 3; k++) begin
      ops8_0[k] = src[k].e8[0];
      ops8_1[k] = src[k].e8[1];
      ops16[k]  = 16'(elem_ext(src[k], sew_i, idx16, src_sgn[k]));
      ops32[k]  = elem_ext(src[k], sew_i, idx32, src_sgn[k]);
    end
  end

  // The 32-bit lane speaks for all, the others run in lockstep
  assign op_ready_o = !valid32 || result_ready_i;
  assign lane_go    = operation_valid_i && op_ready_o;

  // Width of the word now in the lane registers
  always_ff @(posedge clk_i) begin
    if (lane_go) begin
      sew_q <= sew_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////////////////////

  simd_lane #(.Width(8)) i_lane_8b_0 (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .operation_i      (operation_i),
    .operation_valid_i(lane_go && (sew_i == ipu_op_pkg::EW_8)),
    .op_s1_i          (ops8_0[0]),
    .op_s2_i          (ops8_0[1]),
    .op_d_i           (ops8_0[2]),
    .is_signed_i      (is_signed),
    .carry_i          (carry_i[0]),
    .sew_i            (sew_i),
    .result_ready_i   (result_ready_i),
    .result_o         (res8_0),
    .result_valid_o   ()
  );

  simd_lane #(.Width(8)) i_lane_8b_1 (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .operation_i      (operation_i),
    .operation_valid_i(lane_go && (sew_i == ipu_op_pkg::EW_8)),
    .op_s1_i          (ops8_1[0]),
    .op_s2_i          (ops8_1[1]),
    .op_d_i           (ops8_1[2]),
    .is_signed_i      (is_signed),
    .carry_i          (carry_i[1]),
    .sew_i            (sew_i),
    .result_ready_i   (result_ready_i),
    .result_o         (res8_1),
    .result_valid_o   ()
  );

  simd_lane #(.Width(16)) i_lane_16b (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .operation_i      (operation_i),
    .operation_valid_i(lane_go && (sew_i inside {ipu_op_pkg::EW_8, ipu_op_pkg::EW_16})),
    .op_s1_i          (ops16[0]),
    .op_s2_i          (ops16[1]),
    .op_d_i           (ops16[2]),
    .is_signed_i      (is_signed),
    .carry_i          (carry_i[idx16]),
    .sew_i            (sew_i),
    .result_ready_i   (result_ready_i),
    .result_o         (res16),
    .result_valid_o   ()
  );

  simd_lane #(.Width(32)) i_lane_32b (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .operation_i      (operation_i),
    .operation_valid_i(lane_go),
    .op_s1_i          (ops32[0]),
    .op_s2_i          (ops32[1]),
    .op_d_i           (ops32[2]),
    .is_signed_i      (is_signed),
    .carry_i          (carry_i[idx32]),
    .sew_i            (sew_i),
    .result_ready_i   (result_ready_i),
    .result_o         (res32),
    .result_valid_o   (valid32)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Collector
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : collector
    result_o.e32 = res32;
    unique case (sew_q)
      ipu_op_pkg::EW_8: begin
        result_o.e8[0] = res8_0;
        result_o.e8[1] = res8_1;
        result_o.e8[2] = res16[7:0];
        result_o.e8[3] = res32[7:0];
      end
      ipu_op_pkg::EW_16: begin
        result_o.e16[0] = res16;
        result_o.e16[1] = res32[15:0];
      end
      default: ;
    endcase
  end

  assign result_valid_o = valid32;

endmodule

// File: rtl/result_queue.sv
////////////////////////////////////////////////////////////////////////////
// First-word-fall-through queue for finished result words. The head entry
// is on pop_data_o whenever pop_valid_o is high.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "ipu_settings.svh"

module result_queue #(
  parameter int unsigned Depth = `IPU_QUEUE_DEPTH
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [`IPU_ELEN-1:0] push_data_i,
  input  logic                 push_valid_i,
  output logic                 push_ready_o,
  output logic [`IPU_ELEN-1:0] pop_data_o,
  output logic                 pop_valid_o,
  input  logic                 pop_ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic [`IPU_ELEN-1:0] mem_q [Depth];
  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  logic [CntWidth-1:0]  count_q;
  logic                 full;
  logic                 push;
  logic                 pop;

  assign full        = count_q == CntWidth'(Depth);
  assign pop_valid_o = count_q != '0;
  assign pop_data_o  = mem_q[rd_ptr_q];

  // A full queue still takes a word in the cycle its head leaves
  assign push_ready_o = !full || pop_ready_i;

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// File: rtl/vector_int_unit.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the vector integer unit: SIMD lanes followed by a result
// queue. One register stage in the lanes, one in the queue.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "ipu_settings.svh"

module vector_int_unit (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Operation request
  input  ipu_op_pkg::op_e          operation_i,
  input  ipu_op_pkg::sew_e         sew_i,
  input  ipu_data_pkg::elem_word_u op_s1_i,
  input  ipu_data_pkg::elem_word_u op_s2_i,
  input  ipu_data_pkg::elem_word_u op_d_i,
  input  ipu_data_pkg::carry_t     carry_i,
  input  logic                     operation_valid_i,
  output logic                     op_ready_o,
  // Result stream
  output logic [`IPU_ELEN-1:0]     out_result_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i
);

  ipu_data_pkg::elem_word_u ipu_result;
  logic                     ipu_result_valid;
  logic                     queue_ready;

  simd_ipu i_simd_ipu (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .operation_i      (operation_i),
    .operation_valid_i(operation_valid_i),
    .sew_i            (sew_i),
    .op_s1_i          (op_s1_i),
    .op_s2_i          (op_s2_i),
    .op_d_i           (op_d_i),
    .carry_i          (carry_i),
    .result_ready_i   (queue_ready),
    .op_ready_o       (op_ready_o),
    .result_o         (ipu_result),
    .result_valid_o   (ipu_result_valid)
  );

  // Buffers results while the consumer stalls
  result_queue #(.Depth(`IPU_QUEUE_DEPTH)) i_result_queue (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_data_i (ipu_result),
    .push_valid_i(ipu_result_valid),
    .push_ready_o(queue_ready),
    .pop_data_o  (out_result_o),
    .pop_valid_o (out_valid_o),
    .pop_ready_i (out_ready_i)
  );

endmodule

// File: verification/tb_vector_int_unit.sv
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for the vector integer unit. LFSR stimulus, a
// per-element reference model, and concurrent assertions on the output.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "ipu_settings.svh"

module tb_vector_int_unit;

  localparam int AcceptLimit = 64;
  localparam int DrainLimit  = 200;
  localparam int NumRandom   = 400;

  logic                     clk_i = 1'b0;
  logic                     rst_i;
  ipu_op_pkg::op_e          operation_i;
  ipu_op_pkg::sew_e         sew_i;
  ipu_data_pkg::elem_word_u op_s1_i;
  ipu_data_pkg::elem_word_u op_s2_i;
  ipu_data_pkg::elem_word_u op_d_i;
  ipu_data_pkg::carry_t     carry_i;
  logic                     operation_valid_i;
  logic                     op_ready_o;
  logic [`IPU_ELEN-1:0]     out_result_o;
  logic                     out_valid_o;
  logic                     out_ready_i;

  logic [31:0]          lfsr_q = 32'd53;
  logic                 stall_mode = 1'b0;
  logic [`IPU_ELEN-1:0] exp_q [$];
  logic [`IPU_ELEN-1:0] exp_head = '0;
  logic                 exp_valid = 1'b0;
  logic                 accept;
  int                   value_errors = 0;
  int                   protocol_errors = 0;
  int                   timeouts = 0;
  int                   words_seen = 0;

  ipu_op_pkg::sew_e sew_list [3] = '{ipu_op_pkg::EW_32, ipu_op_pkg::EW_16, ipu_op_pkg::EW_8};

  vector_int_unit dut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .operation_i      (operation_i),
    .sew_i            (sew_i),
    .op_s1_i          (op_s1_i),
    .op_s2_i          (op_s2_i),
    .op_d_i           (op_d_i),
    .carry_i          (carry_i),
    .operation_valid_i(operation_valid_i),
    .op_ready_o       (op_ready_o),
    .out_result_o     (out_result_o),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i)
  );

  always #5 clk_i = ~clk_i;

  assign accept = operation_valid_i && op_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
    end
    return val;
  endfunction

  function automatic ipu_op_pkg::op_e pick_op();
    return ipu_op_pkg::op_e'(take_bits(4) % 14);
  endfunction

  // Code 3 is not a width, fold it onto EW_8
  function automatic ipu_op_pkg::sew_e choose_sew();
    logic [1:0] code;
    code = 2'(take_bits(2));
    return (code == 2'b11) ? ipu_op_pkg::EW_8 : ipu_op_pkg::sew_e'(code);
  endfunction

  task automatic drive_ready();
    if (stall_mode) begin
      out_ready_i <= take_bits(1) != 32'd0;
    end else begin
      out_ready_i <= 1'b1;
    end
  endtask

  task automatic idle_cycles(input int n);
    operation_valid_i <= 1'b0;
    repeat (n) begin
      @(posedge clk_i);
      drive_ready();
    end
  endtask

  // Called on a rising edge, returns on the edge that accepts the operation
  task automatic issue_op(input ipu_op_pkg::op_e op, input ipu_op_pkg::sew_e sew,
                          input logic [31:0] s1, input logic [31:0] s2,
                          input logic [31:0] d, input logic [3:0] carry);
    logic accepted;
    int   waited;
    accepted = 1'b0;
    waited   = 0;
    operation_i       <= op;
    sew_i             <= sew;
    op_s1_i           <= s1;
    op_s2_i           <= s2;
    op_d_i            <= d;
    carry_i           <= carry;
    operation_valid_i <= 1'b1;
    while (!accepted && waited < AcceptLimit) begin
      @(negedge clk_i);
      accepted = op_ready_o;
      @(posedge clk_i);
      drive_ready();
      waited++;
    end
    operation_valid_i <= 1'b0;
    if (!accepted) begin
      timeouts++;
      $display("Timed out at %0t waiting for the unit to accept an operation", $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // One element of width w; subtract takes source 1 from source 2
  function automatic logic [31:0] elem_result(input ipu_op_pkg::op_e op, input logic [31:0] a,
                                              input logic [31:0] b, input logic [31:0] d,
                                              input logic c, input int w);
    logic [63:0]        mask;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] r;
    mask = (64'd1 << w) - 64'd1;
    ua   = {32'd0, a} & mask;
    ub   = {32'd0, b} & mask;
    sa   = $signed(ua << (64 - w)) >>> (64 - w);
    sb   = $signed(ub << (64 - w)) >>> (64 - w);
    case (op)
      ipu_op_pkg::VADD:    r = ua + ub;
      ipu_op_pkg::VSUB:    r = ub - ua;
      ipu_op_pkg::VADC:    r = ua + ub + c;
      ipu_op_pkg::VAND:    r = ua & ub;
      ipu_op_pkg::VOR:     r = ua | ub;
      ipu_op_pkg::VXOR:    r = ua ^ ub;
      ipu_op_pkg::VMINU:   r = (ua < ub) ? ua : ub;
      ipu_op_pkg::VMIN:    r = (sa < sb) ? ua : ub;
      ipu_op_pkg::VMAXU:   r = (ua < ub) ? ub : ua;
      ipu_op_pkg::VMAX:    r = (sa < sb) ? ub : ua;
      ipu_op_pkg::VMUL:    r = ua * ub;
      ipu_op_pkg::VMULH:   r = (sa * sb) >>> w;
      ipu_op_pkg::VMULHU:  r = (ua * ub) >> w;
      // Source 1 unsigned, source 2 signed
      ipu_op_pkg::VMULHSU: r = (sb * $signed(ua)) >>> w;
      default:             r = {32'd0, d};
    endcase
    return 32'(r & mask);
  endfunction

  function automatic logic [31:0] expected_word(input ipu_op_pkg::op_e op,
                                                input ipu_op_pkg::sew_e sew,
                                                input ipu_data_pkg::elem_word_u s1,
                                                input ipu_data_pkg::elem_word_u s2,
                                                input ipu_data_pkg::elem_word_u d,
                                                input ipu_data_pkg::carry_t carry);
    ipu_data_pkg::elem_word_u res;
    res.e32 = '0;
    case (sew)
      ipu_op_pkg::EW_8: begin
        for (int i = 0; i < 4; i++) begin
          res.e8[i] = 8'(elem_result(op, s1.e8[i], s2.e8[i], d.e8[i], carry[i], 8));
        end
      end
      ipu_op_pkg::EW_16: begin
        for (int i = 0; i < 2; i++) begin
          res.e16[i] = 16'(elem_result(op, s1.e16[i], s2.e16[i], d.e16[i], carry[i], 16));
        end
      end
      default: res.e32 = elem_result(op, s1.e32, s2.e32, d.e32, carry[0], 32);
    endcase
    return res.e32;
  endfunction

  // Expected words in acceptance order, head kept for the assertions
  always @(posedge clk_i) begin
    if (rst_i) begin
      exp_q.delete();
    end else begin
      if (out_valid_o && out_ready_i && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        words_seen++;
      end
      if (accept) begin
        exp_q.push_back(expected_word(operation_i, sew_i, op_s1_i, op_s2_i, op_d_i, carry_i));
      end
    end
    exp_valid <= exp_q.size() != 0;
    exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk_i) disable iff (rst_i)
    (out_valid_o && out_ready_i && exp_valid) |-> (out_result_o == exp_head))
    else begin
      value_errors++;
      $display("ERROR %0t: result %h, expected %h", $time, out_result_o, exp_head);
    end

  assert property (@(posedge clk_i) disable iff (rst_i)
    (out_valid_o && out_ready_i) |-> exp_valid)
    else begin
      protocol_errors++;
      $display("A result left the unit at %0t with no operation waiting for it", $time);
    end

  assert property (@(posedge clk_i) disable iff (rst_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_result_o)))
    else begin
      protocol_errors++;
      $display("The output word changed or vanished during a stall at %0t", $time);
    end

  assert property (@(posedge clk_i) disable iff (rst_i)
    !op_ready_o |-> (dut.i_simd_ipu.result_valid_o && !out_ready_i))
    else begin
      protocol_errors++;
      $display("op_ready_o was low at %0t with no result held back", $time);
    end

  // Empty pipeline gives a fixed two-cycle latency
  assert property (@(posedge clk_i) disable iff (rst_i)
    (accept && !out_valid_o && !dut.i_simd_ipu.result_valid_o) |=> !out_valid_o ##1 out_valid_o)
    else begin
      protocol_errors++;
      $display("A result missed its two-cycle latency at %0t", $time);
    end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int gap;
    int waited;
    rst_i             = 1'b1;
    operation_i       = ipu_op_pkg::VADD;
    sew_i             = ipu_op_pkg::EW_32;
    op_s1_i           = '0;
    op_s2_i           = '0;
    op_d_i            = '0;
    carry_i           = '0;
    operation_valid_i = 1'b0;
    out_ready_i       = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    @(negedge clk_i);
    assert (!out_valid_o && op_ready_o)
      else begin
        protocol_errors++;
        $display("Outputs after reset are not idle and ready");
      end
    @(posedge clk_i);

    // Every operation at every width, one at a time
    for (int s = 0; s < 3 && timeouts == 0; s++) begin
      for (int k = 0; k < 14 && timeouts == 0; k++) begin
        issue_op(ipu_op_pkg::op_e'(k), sew_list[s], take_bits(32), take_bits(32),
                 take_bits(32), 4'(take_bits(4)));
        idle_cycles(3);
      end
    end

    // Carries must stay inside their element
    issue_op(ipu_op_pkg::VADC, ipu_op_pkg::EW_8, 32'hFFFF_FFFF, 32'hFFFF_FFFF, '0, 4'hF);
    issue_op(ipu_op_pkg::VADC, ipu_op_pkg::EW_16, 32'hFFFF_FFFF, 32'hFFFF_0001, '0, 4'h3);
    issue_op(ipu_op_pkg::VMULH, ipu_op_pkg::EW_8, 32'h8080_7F80, 32'h80FF_7F7F, '0, 4'h0);
    idle_cycles(3);

    // Random traffic against a stalling consumer
    stall_mode = 1'b1;
    for (int n = 0; n < NumRandom && timeouts == 0; n++) begin
      issue_op(pick_op(), choose_sew(), take_bits(32), take_bits(32),
               take_bits(32), 4'(take_bits(4)));
      gap = int'(take_bits(2));
      if (gap > 1) begin
        idle_cycles(gap - 1);
      end
    end

    // Drain
    stall_mode = 1'b0;
    waited     = 0;
    do begin
      @(posedge clk_i);
      drive_ready();
      @(negedge clk_i);
      waited++;
    end while ((exp_q.size() != 0 || out_valid_o) && waited < DrainLimit);
    if (waited >= DrainLimit) begin
      timeouts++;
      $display("Timed out draining results, %0d still expected", exp_q.size());
    end
    assert (exp_q.size() == 0 && !out_valid_o)
      else begin
        protocol_errors++;
        $display("Results were lost or left over after the drain");
      end

    $display("Words checked %0d, value errors %0d, protocol errors %0d, timeouts %0d",
             words_seen, value_errors, protocol_errors, timeouts);
    if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+rtl
rtl/ipu_op_pkg.sv
rtl/ipu_data_pkg.sv
rtl/simd_lane.sv
rtl/simd_ipu.sv
rtl/result_queue.sv
rtl/vector_int_unit.sv
verification/tb_vector_int_unit.sv
